/* test/axi_xbar_stim.txt */
# name master(0/1/both) op(W/R) addr wdata strb resp(0 OKAY,3 DECERR) rdata, all hex
# rdata is checked for reads only
rr_first both W 00000040 11223344 f 0 00000000
w_m0_s0 0 W 00000010 cafe0001 f 0 00000000
r_m0_s0 0 R 00000010 00000000 0 0 cafe0001
w_m0_s1 0 W 00010020 cafe0002 f 0 00000000
r_m0_s1 0 R 00010020 00000000 0 0 cafe0002
w_m1_s0 1 W 00000030 cafe0003 f 0 00000000
r_m1_s0 1 R 00000030 00000000 0 0 cafe0003
w_m1_s1 1 W 00010034 cafe0004 f 0 00000000
r_m1_s1 1 R 00010034 00000000 0 0 cafe0004
r_cross 0 R 00010034 00000000 0 0 cafe0004
w_full 0 W 00000050 aabbccdd f 0 00000000
w_part 1 W 00000050 11223344 5 0 00000000
r_part 0 R 00000050 00000000 0 0 aa22cc44
w_dec 1 W 00020000 deadbeef f 3 00000000
r_dec 0 R 00050010 00000000 0 3 00000000
rr_second both R 00000040 00000000 0 0 11223344
w_stress0 1 W 000100fc 5a5a5a5a f 0 00000000
r_stress0 0 R 000100fc 00000000 0 0 5a5a5a5a
rr_third both R 00010020 00000000 0 0 cafe0002

/* axi_xbar.f */
common/axi_xbar_pkg.sv
arbiter/rr_arbiter.sv
source/master_mux.sv
source/slave_decoder.sv
source/axi_xbar.sv
test/axi_xbar_checker.sv
test/axi_xbar_tb.sv

/* Makefile */
# Verilator flow for the AXI4-Lite shared-bus interconnect

SIM = obj_dir/axi_xbar_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -sv -f axi_xbar.f --top-module axi_xbar_tb -o axi_xbar_sim

run: compile
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/axi_xbar_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_xbar_tb;

	logic ACLK;
	logic ARESETn;
	logic [1:0][31:0] m_awaddr;
	logic [1:0] m_awvalid;
	logic [1:0] m_awready;
	logic [1:0][31:0] m_wdata;
	logic [1:0][3:0] m_wstrb;
	logic [1:0] m_wvalid;
	logic [1:0] m_wready;
	logic [1:0][1:0] m_bresp;
	logic [1:0] m_bvalid;
	logic [1:0] m_bready;
	logic [1:0][31:0] m_araddr;
	logic [1:0] m_arvalid;
	logic [1:0] m_arready;
	logic [1:0][31:0] m_rdata;
	logic [1:0][1:0] m_rresp;
	logic [1:0] m_rvalid;
	logic [1:0] m_rready;
	logic [1:0][31:0] s_awaddr;
	logic [1:0] s_awvalid;
	logic [1:0] s_awready;
	logic [1:0][31:0] s_wdata;
	logic [1:0][3:0] s_wstrb;
	logic [1:0] s_wvalid;
	logic [1:0] s_wready;
	logic [1:0][1:0] s_bresp;
	logic [1:0] s_bvalid;
	logic [1:0] s_bready;
	logic [1:0][31:0] s_araddr;
	logic [1:0] s_arvalid;
	logic [1:0] s_arready;
	logic [1:0][31:0] s_rdata;
	logic [1:0][1:0] s_rresp;
	logic [1:0] s_rvalid;
	logic [1:0] s_rready;

	// Slave model state
	logic [31:0] mem [2][256];
	logic [1:0] have_aw;
	logic [1:0] have_w;
	logic [1:0] have_ar;
	logic [1:0][7:0] aw_idx;
	logic [1:0][31:0] w_data;
	logic [1:0][3:0] w_strb;
	// Cycles with any slave valid high
	int hits;
	// Masters in completion order
	int done_order[$];

	axi_xbar uut (.*);

	always #2 ACLK = ~ACLK;

	// ====================
	// Slave models
	// ====================
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			s_awready <= '0;
			s_wready <= '0;
			s_arready <= '0;
			s_bvalid <= '0;
			s_rvalid <= '0;
			s_bresp <= '0;
			s_rresp <= '0;
			s_rdata <= '0;
			have_aw <= '0;
			have_w <= '0;
			have_ar <= '0;
			aw_idx <= '0;
			w_data <= '0;
			w_strb <= '0;
			hits <= 0;
			// Fill tied to slave and word index
			for (int s = 0; s < 2; s++)
				for (int j = 0; j < 256; j++)
					mem[s][j] <= {8'hA0 + 8'(s), 24'(j)};
		end else begin
			if (|{s_awvalid, s_wvalid, s_arvalid})
				hits <= hits + 1;
			for (int s = 0; s < 2; s++) begin
				if (s_awvalid[s] && s_awready[s]) begin
					have_aw[s] <= 1'b1;
					aw_idx[s] <= s_awaddr[s][9:2];
				end
				if (s_wvalid[s] && s_wready[s]) begin
					have_w[s] <= 1'b1;
					w_data[s] <= s_wdata[s];
					w_strb[s] <= s_wstrb[s];
				end
				// Random ready with one beat per transaction
				s_awready[s] <= !have_aw[s] && !(s_awvalid[s] && s_awready[s])
					&& ($urandom_range(0, 3) != 0);
				s_wready[s] <= !have_w[s] && !(s_wvalid[s] && s_wready[s])
					&& ($urandom_range(0, 3) != 0);
				s_arready[s] <= !have_ar[s] && !(s_arvalid[s] && s_arready[s])
					&& ($urandom_range(0, 3) != 0);
				// Byte merge once address and data are both in
				if (have_aw[s] && have_w[s] && !s_bvalid[s]) begin
					for (int b = 0; b < 4; b++)
						if (w_strb[s][b])
							mem[s][aw_idx[s]][8*b +: 8] <= w_data[s][8*b +: 8];
					s_bvalid[s] <= 1'b1;
				end
				if (s_bvalid[s] && s_bready[s]) begin
					s_bvalid[s] <= 1'b0;
					have_aw[s] <= 1'b0;
					have_w[s] <= 1'b0;
				end
				if (s_arvalid[s] && s_arready[s]) begin
					have_ar[s] <= 1'b1;
					s_rdata[s] <= mem[s][s_araddr[s][9:2]];
					s_rvalid[s] <= 1'b1;
				end
				if (s_rvalid[s] && s_rready[s]) begin
					s_rvalid[s] <= 1'b0;
					have_ar[s] <= 1'b0;
				end
			end
		end
	end

	// ====================
	// Reporting
	// ====================
	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic stop_timeout(input string name);
		$display("Timeout in %s: no response from the DUT within 200 cycles", name);
		$display("CHECKS FAILED");
		$fatal(1, "timeout");
	endtask

	// ====================
	// Master drivers
	// ====================
	// Handshakes are seen at the falling edge and take effect at the next rising edge
	task automatic run_write(input string name, input int m, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] strb, output logic [1:0] resp);
		int cyc;
		bit aw_ok;
		bit w_ok;
		bit b_ok;

		cyc = 0;
		aw_ok = 1'b0;
		w_ok = 1'b0;
		b_ok = 1'b0;
		m_awaddr[m] = addr;
		m_awvalid[m] = 1'b1;
		m_wdata[m] = data;
		m_wstrb[m] = strb;
		m_wvalid[m] = 1'b1;
		while (!b_ok) begin
			@(negedge ACLK);
			if (m_awvalid[m] && m_awready[m])
				aw_ok = 1'b1;
			if (m_wvalid[m] && m_wready[m])
				w_ok = 1'b1;
			if (m_bvalid[m] && m_bready[m]) begin
				b_ok = 1'b1;
				resp = m_bresp[m];
			end
			@(posedge ACLK);
			#1;
			if (aw_ok)
				m_awvalid[m] = 1'b0;
			if (w_ok)
				m_wvalid[m] = 1'b0;
			m_bready[m] = !b_ok && ($urandom_range(0, 2) == 0);
			cyc++;
			if (cyc > 200)
				stop_timeout(name);
		end
		done_order.push_back(m);
	endtask

	task automatic run_read(input string name, input int m, input logic [31:0] addr,
			output logic [1:0] resp, output logic [31:0] data);
		int cyc;
		bit ar_ok;
		bit r_ok;

		cyc = 0;
		ar_ok = 1'b0;
		r_ok = 1'b0;
		m_araddr[m] = addr;
		m_arvalid[m] = 1'b1;
		while (!r_ok) begin
			@(negedge ACLK);
			if (m_arvalid[m] && m_arready[m])
				ar_ok = 1'b1;
			if (m_rvalid[m] && m_rready[m]) begin
				r_ok = 1'b1;
				resp = m_rresp[m];
				data = m_rdata[m];
			end
			@(posedge ACLK);
			#1;
			if (ar_ok)
				m_arvalid[m] = 1'b0;
			m_rready[m] = !r_ok && ($urandom_range(0, 2) == 0);
			cyc++;
			if (cyc > 200)
				stop_timeout(name);
		end
		done_order.push_back(m);
	endtask

	// One transaction from master m checked against the file
	task automatic run_one(input string name, input int m, input string op,
			input logic [31:0] addr, input logic [31:0] wdata, input logic [3:0] strb,
			input logic [1:0] eresp, input logic [31:0] erdata);
		logic [1:0] resp;
		logic [31:0] data;

		if (op == "W") begin
			run_write(name, m, addr, wdata, strb, resp);
		end else begin
			run_read(name, m, addr, resp, data);
			check_value(name, erdata, data);
		end
		check_value(name, 32'(eresp), 32'(resp));
	endtask

	// ====================
	// Stimulus
	// ====================
	initial begin
		int fd;
		int n;
		int ptr_model;
		int first;
		int hits_before;
		string line;
		string name;
		string who;
		string op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0] strb;
		logic [1:0] eresp;
		logic [31:0] erdata;

		void'($urandom(85099));
		ACLK = 1'b0;
		ARESETn = 1'b0;
		m_awaddr = '0;
		m_awvalid = '0;
		m_wdata = '0;
		m_wstrb = '0;
		m_wvalid = '0;
		m_bready = '0;
		m_araddr = '0;
		m_arvalid = '0;
		m_rready = '0;
		// Round-robin pointer starts at master 0
		ptr_model = 0;
		repeat (10) @(posedge ACLK);
		#1;
		ARESETn = 1'b1;
		fd = $fopen("test/axi_xbar_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file test/axi_xbar_stim.txt");
			$display("CHECKS FAILED");
			$fatal(1, "no stimulus");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 4 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %s %s %h %h %h %h %h",
				name, who, op, addr, wdata, strb, eresp, erdata);
			if (n != 8)
				continue;
			@(posedge ACLK);
			#1;
			done_order.delete();
			hits_before = hits;
			if (who == "both") begin
				first = ptr_model;
				fork
					run_one(name, 0, op, addr, wdata, strb, eresp, erdata);
					run_one(name, 1, op, addr, wdata, strb, eresp, erdata);
				join
				check_value({name, " order"}, 32'(first), 32'(done_order[0]));
			end else begin
				run_one(name, who.atoi(), op, addr, wdata, strb, eresp, erdata);
			end
			// Pointer moves past each master that finished
			foreach (done_order[i])
				ptr_model = 1 - done_order[i];
			if (eresp == axi_xbar_pkg::RESP_DECERR)
				check_value({name, " slave hits"}, 32'(hits_before), 32'(hits));
		end
		$fclose(fd);
		if (uut.u_checker.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("Protocol assertions failed %0d times", uut.u_checker.fail_count);
			$display("CHECKS FAILED");
			$fatal(1, "protocol assertion failure");
		end
	end

endmodule

`default_nettype wire

/* test/axi_xbar_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_xbar_checker (
	input logic ACLK,
	input logic ARESETn,
	input logic [axi_xbar_pkg::NUM_S-1:0] s_awvalid,
	input logic [axi_xbar_pkg::NUM_S-1:0] s_wvalid,
	input logic [axi_xbar_pkg::NUM_S-1:0] s_arvalid,
	input logic [axi_xbar_pkg::NUM_M-1:0] m_bvalid,
	input logic [axi_xbar_pkg::NUM_M-1:0] m_rvalid,
	input logic owner,
	input logic busy,
	input logic bus_bvalid,
	input logic bus_bready,
	input logic bus_rvalid,
	input logic bus_rready
);

	// Failed property count
	int fail_count = 0;

	// ====================
	// Protocol properties
	// ====================
	// At most one slave sees a request
	a_one_aw: assert property (@(posedge ACLK) disable iff (!ARESETn) $onehot0(s_awvalid))
		else begin
			fail_count++;
			$error("two slaves see AWVALID");
		end
	a_one_w: assert property (@(posedge ACLK) disable iff (!ARESETn) $onehot0(s_wvalid))
		else begin
			fail_count++;
			$error("two slaves see WVALID");
		end
	a_one_ar: assert property (@(posedge ACLK) disable iff (!ARESETn) $onehot0(s_arvalid))
		else begin
			fail_count++;
			$error("two slaves see ARVALID");
		end

	// Grant fixed while the bus is owned
	a_owner: assert property (@(posedge ACLK) disable iff (!ARESETn) busy |=> $stable(owner))
		else begin
			fail_count++;
			$error("owner changed during a transaction");
		end

	// Responses wait for ready
	a_bhold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		bus_bvalid && !bus_bready |=> bus_bvalid)
		else begin
			fail_count++;
			$error("BVALID dropped before BREADY");
		end
	a_rhold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		bus_rvalid && !bus_rready |=> bus_rvalid)
		else begin
			fail_count++;
			$error("RVALID dropped before RREADY");
		end

	// Quiet bus right out of reset
	a_reset: assert property (@(posedge ACLK) $rose(ARESETn) |->
		!(|s_awvalid) && !(|s_wvalid) && !(|s_arvalid) && !(|m_bvalid) && !(|m_rvalid))
		else begin
			fail_count++;
			$error("valid high just after reset");
		end

endmodule

bind axi_xbar axi_xbar_checker u_checker (.*);

`default_nettype wire

/* source/axi_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_xbar (
	input logic ACLK,
	input logic ARESETn,
	// ====================
	// Master ports
	// ====================
	input logic [axi_xbar_pkg::NUM_M-1:0][axi_xbar_pkg::ADDR_W-1:0] m_awaddr,
	input logic [axi_xbar_pkg::NUM_M-1:0] m_awvalid,
	output logic [axi_xbar_pkg::NUM_M-1:0] m_awready,
	input logic [axi_xbar_pkg::NUM_M-1:0][axi_xbar_pkg::DATA_W-1:0] m_wdata,
	input logic [axi_xbar_pkg::NUM_M-1:0][axi_xbar_pkg::STRB_W-1:0] m_wstrb,
	input logic [axi_xbar_pkg::NUM_M-1:0] m_wvalid,
	output logic [axi_xbar_pkg::NUM_M-1:0] m_wready,
	output axi_xbar_pkg::resp_t [axi_xbar_pkg::NUM_M-1:0] m_bresp,
	output logic [axi_xbar_pkg::NUM_M-1:0] m_bvalid,
	input logic [axi_xbar_pkg::NUM_M-1:0] m_bready,
	input logic [axi_xbar_pkg::NUM_M-1:0][axi_xbar_pkg::ADDR_W-1:0] m_araddr,
	input logic [axi_xbar_pkg::NUM_M-1:0] m_arvalid,
	output logic [axi_xbar_pkg::NUM_M-1:0] m_arready,
	output logic [axi_xbar_pkg::NUM_M-1:0][axi_xbar_pkg::DATA_W-1:0] m_rdata,
	output axi_xbar_pkg::resp_t [axi_xbar_pkg::NUM_M-1:0] m_rresp,
	output logic [axi_xbar_pkg::NUM_M-1:0] m_rvalid,
	input logic [axi_xbar_pkg::NUM_M-1:0] m_rready,
	// ====================
	// Slave ports
	// ====================
	output logic [axi_xbar_pkg::NUM_S-1:0][axi_xbar_pkg::ADDR_W-1:0] s_awaddr,
	output logic [axi_xbar_pkg::NUM_S-1:0] s_awvalid,
	input logic [axi_xbar_pkg::NUM_S-1:0] s_awready,
	output logic [axi_xbar_pkg::NUM_S-1:0][axi_xbar_pkg::DATA_W-1:0] s_wdata,
	output logic [axi_xbar_pkg::NUM_S-1:0][axi_xbar_pkg::STRB_W-1:0] s_wstrb,
	output logic [axi_xbar_pkg::NUM_S-1:0] s_wvalid,
	input logic [axi_xbar_pkg::NUM_S-1:0] s_wready,
	input axi_xbar_pkg::resp_t [axi_xbar_pkg::NUM_S-1:0] s_bresp,
	input logic [axi_xbar_pkg::NUM_S-1:0] s_bvalid,
	output logic [axi_xbar_pkg::NUM_S-1:0] s_bready,
	output logic [axi_xbar_pkg::NUM_S-1:0][axi_xbar_pkg::ADDR_W-1:0] s_araddr,
	output logic [axi_xbar_pkg::NUM_S-1:0] s_arvalid,
	input logic [axi_xbar_pkg::NUM_S-1:0] s_arready,
	input logic [axi_xbar_pkg::NUM_S-1:0][axi_xbar_pkg::DATA_W-1:0] s_rdata,
	input axi_xbar_pkg::resp_t [axi_xbar_pkg::NUM_S-1:0] s_rresp,
	input logic [axi_xbar_pkg::NUM_S-1:0] s_rvalid,
	output logic [axi_xbar_pkg::NUM_S-1:0] s_rready
);

	// Grant state
	logic owner;
	logic busy;
	logic is_write;

	// Shared bus, mux side to decoder side
	logic [axi_xbar_pkg::ADDR_W-1:0] bus_awaddr;
	logic bus_awvalid;
	logic [axi_xbar_pkg::DATA_W-1:0] bus_wdata;
	logic [axi_xbar_pkg::STRB_W-1:0] bus_wstrb;
	logic bus_wvalid;
	logic bus_bready;
	logic [axi_xbar_pkg::ADDR_W-1:0] bus_araddr;
	logic bus_arvalid;
	logic bus_rready;

	// Shared bus, decoder side back to mux
	logic bus_awready;
	logic bus_wready;
	axi_xbar_pkg::resp_t bus_bresp;
	logic bus_bvalid;
	logic bus_arready;
	logic [axi_xbar_pkg::DATA_W-1:0] bus_rdata;
	axi_xbar_pkg::resp_t bus_rresp;
	logic bus_rvalid;

	// Port names match the wires above
	rr_arbiter u_arbiter (.*);

	master_mux u_master_mux (.*);

	slave_decoder u_slave_decoder (.*);

endmodule

`default_nettype wire

/* source/slave_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module slave_decoder (
	input logic ACLK,
	input logic ARESETn,
	// Shared bus requests
	input logic [axi_xbar_pkg::ADDR_W-1:0] bus_awaddr,
	input logic bus_awvalid,
	input logic [axi_xbar_pkg::DATA_W-1:0] bus_wdata,
	input logic [axi_xbar_pkg::STRB_W-1:0] bus_wstrb,
	input logic bus_wvalid,
	input logic bus_bready,
	input logic [axi_xbar_pkg::ADDR_W-1:0] bus_araddr,
	input logic bus_arvalid,
	input logic bus_rready,
	// Slave returns
	input logic [axi_xbar_pkg::NUM_S-1:0] s_awready,
	input logic [axi_xbar_pkg::NUM_S-1:0] s_wready,
	input axi_xbar_pkg::resp_t [axi_xbar_pkg::NUM_S-1:0] s_bresp,
	input logic [axi_xbar_pkg::NUM_S-1:0] s_bvalid,
	input logic [axi_xbar_pkg::NUM_S-1:0] s_arready,
	input logic [axi_xbar_pkg::NUM_S-1:0][axi_xbar_pkg::DATA_W-1:0] s_rdata,
	input axi_xbar_pkg::resp_t [axi_xbar_pkg::NUM_S-1:0] s_rresp,
	input logic [axi_xbar_pkg::NUM_S-1:0] s_rvalid,
	// Slave requests
	output logic [axi_xbar_pkg::NUM_S-1:0][axi_xbar_pkg::ADDR_W-1:0] s_awaddr,
	output logic [axi_xbar_pkg::NUM_S-1:0] s_awvalid,
	output logic [axi_xbar_pkg::NUM_S-1:0][axi_xbar_pkg::DATA_W-1:0] s_wdata,
	output logic [axi_xbar_pkg::NUM_S-1:0][axi_xbar_pkg::STRB_W-1:0] s_wstrb,
	output logic [axi_xbar_pkg::NUM_S-1:0] s_wvalid,
	output logic [axi_xbar_pkg::NUM_S-1:0] s_bready,
	output logic [axi_xbar_pkg::NUM_S-1:0][axi_xbar_pkg::ADDR_W-1:0] s_araddr,
	output logic [axi_xbar_pkg::NUM_S-1:0] s_arvalid,
	output logic [axi_xbar_pkg::NUM_S-1:0] s_rready,
	// Shared bus returns
	output logic bus_awready,
	output logic bus_wready,
	output axi_xbar_pkg::resp_t bus_bresp,
	output logic bus_bvalid,
	output logic bus_arready,
	output logic [axi_xbar_pkg::DATA_W-1:0] bus_rdata,
	output axi_xbar_pkg::resp_t bus_rresp,
	output logic bus_rvalid
);

	// One-hot slave select, all zero when unmapped
	logic [axi_xbar_pkg::NUM_S-1:0] aw_dec;
	logic [axi_xbar_pkg::NUM_S-1:0] ar_dec;
	logic [axi_xbar_pkg::NUM_S-1:0] wr_sel;
	logic [axi_xbar_pkg::NUM_S-1:0] rd_sel;
	// Target held after the address handshake
	logic [axi_xbar_pkg::NUM_S-1:0] wr_tgt;
	logic [axi_xbar_pkg::NUM_S-1:0] rd_tgt;
	logic aw_done;
	logic w_done;
	logic ar_done;
	// Locally generated error responses
	logic dec_bvalid;
	logic dec_rvalid;
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	logic ar_hs;
	logic r_hs;

	// Region field picks the slave
	function automatic logic [axi_xbar_pkg::NUM_S-1:0] region_dec(
		input logic [axi_xbar_pkg::ADDR_W-1:0] addr
	);
		axi_xbar_pkg::axi_addr_u view;
		logic [axi_xbar_pkg::NUM_S-1:0] sel;

		view.raw = addr;
		sel = '0;
		if (view.fields.region == axi_xbar_pkg::REGION_S0)
			sel[0] = 1'b1;
		else if (view.fields.region == axi_xbar_pkg::REGION_S1)
			sel[1] = 1'b1;
		return sel;
	endfunction

	assign aw_dec = region_dec(bus_awaddr);
	assign ar_dec = region_dec(bus_araddr);

	// Live decode until the address is taken, then the latch
	assign wr_sel = aw_done ? wr_tgt : aw_dec;
	assign rd_sel = ar_done ? rd_tgt : ar_dec;

	assign aw_hs = bus_awvalid & bus_awready;
	assign w_hs = bus_wvalid & bus_wready;
	assign b_hs = bus_bvalid & bus_bready;
	assign ar_hs = bus_arvalid & bus_arready;
	assign r_hs = bus_rvalid & bus_rready;

	// ====================
	// Steering to slaves
	// ====================
	for (genvar i = 0; i < axi_xbar_pkg::NUM_S; i++) begin : g_slv
		assign s_awaddr[i] = bus_awaddr;
		assign s_awvalid[i] = bus_awvalid & aw_dec[i];
		assign s_wdata[i] = bus_wdata;
		// Byte merge happens in the slave
		assign s_wstrb[i] = bus_wstrb;
		assign s_wvalid[i] = bus_wvalid & wr_sel[i];
		assign s_bready[i] = bus_bready & wr_sel[i];
		assign s_araddr[i] = bus_araddr;
		assign s_arvalid[i] = bus_arvalid & ar_dec[i];
		assign s_rready[i] = bus_rready & rd_sel[i];
	end

	// Unmapped requests are swallowed here
	assign bus_awready = (aw_dec == '0) | (|(s_awready & aw_dec));
	assign bus_wready = (wr_sel == '0) | (|(s_wready & wr_sel));
	assign bus_arready = (ar_dec == '0) | (|(s_arready & ar_dec));

	// ====================
	// Response return
	// ====================
	always_comb begin
		bus_bvalid = dec_bvalid;
		bus_bresp = dec_bvalid ? axi_xbar_pkg::RESP_DECERR : axi_xbar_pkg::RESP_OKAY;
		bus_rvalid = dec_rvalid;
		bus_rresp = dec_rvalid ? axi_xbar_pkg::RESP_DECERR : axi_xbar_pkg::RESP_OKAY;
		// Error reads return zero data
		bus_rdata = '0;
		for (int i = 0; i < axi_xbar_pkg::NUM_S; i++) begin
			if (wr_sel[i]) begin
				bus_bvalid = s_bvalid[i];
				bus_bresp = s_bresp[i];
			end
			if (rd_sel[i]) begin
				bus_rvalid = s_rvalid[i];
				bus_rresp = s_rresp[i];
				bus_rdata = s_rdata[i];
			end
		end
	end

	// Write progress, closed by the B handshake
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			aw_done <= 1'b0;
			w_done <= 1'b0;
			wr_tgt <= '0;
			dec_bvalid <= 1'b0;
		end else if (b_hs) begin
			aw_done <= 1'b0;
			w_done <= 1'b0;
			dec_bvalid <= 1'b0;
		end else begin
			if (aw_hs) begin
				aw_done <= 1'b1;
				wr_tgt <= aw_dec;
			end
			if (w_hs)
				w_done <= 1'b1;
			// Error B once both AW and W are in
			if ((aw_done | aw_hs) & (w_done | w_hs) & (wr_sel == '0))
				dec_bvalid <= 1'b1;
		end
	end

	// Read progress, closed by the R handshake
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			ar_done <= 1'b0;
			rd_tgt <= '0;
			dec_rvalid <= 1'b0;
		end else if (r_hs) begin
			ar_done <= 1'b0;
			dec_rvalid <= 1'b0;
		end else if (ar_hs) begin
			ar_done <= 1'b1;
			rd_tgt <= ar_dec;
			dec_rvalid <= (ar_dec == '0);
		end
	end

endmodule

`default_nettype wire

/* source/master_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module master_mux (
	// Grant from the arbiter
	input logic owner,
	input logic busy,
	input logic is_write,
	// Master request channels
	input logic [axi_xbar_pkg::NUM_M-1:0][axi_xbar_pkg::ADDR_W-1:0] m_awaddr,
	input logic [axi_xbar_pkg::NUM_M-1:0] m_awvalid,
	input logic [axi_xbar_pkg::NUM_M-1:0][axi_xbar_pkg::DATA_W-1:0] m_wdata,
	input logic [axi_xbar_pkg::NUM_M-1:0][axi_xbar_pkg::STRB_W-1:0] m_wstrb,
	input logic [axi_xbar_pkg::NUM_M-1:0] m_wvalid,
	input logic [axi_xbar_pkg::NUM_M-1:0] m_bready,
	input logic [axi_xbar_pkg::NUM_M-1:0][axi_xbar_pkg::ADDR_W-1:0] m_araddr,
	input logic [axi_xbar_pkg::NUM_M-1:0] m_arvalid,
	input logic [axi_xbar_pkg::NUM_M-1:0] m_rready,
	// Returns toward the masters
	output logic [axi_xbar_pkg::NUM_M-1:0] m_awready,
	output logic [axi_xbar_pkg::NUM_M-1:0] m_wready,
	output axi_xbar_pkg::resp_t [axi_xbar_pkg::NUM_M-1:0] m_bresp,
	output logic [axi_xbar_pkg::NUM_M-1:0] m_bvalid,
	output logic [axi_xbar_pkg::NUM_M-1:0] m_arready,
	output logic [axi_xbar_pkg::NUM_M-1:0][axi_xbar_pkg::DATA_W-1:0] m_rdata,
	output axi_xbar_pkg::resp_t [axi_xbar_pkg::NUM_M-1:0] m_rresp,
	output logic [axi_xbar_pkg::NUM_M-1:0] m_rvalid,
	// Shared bus requests
	output logic [axi_xbar_pkg::ADDR_W-1:0] bus_awaddr,
	output logic bus_awvalid,
	output logic [axi_xbar_pkg::DATA_W-1:0] bus_wdata,
	output logic [axi_xbar_pkg::STRB_W-1:0] bus_wstrb,
	output logic bus_wvalid,
	output logic bus_bready,
	output logic [axi_xbar_pkg::ADDR_W-1:0] bus_araddr,
	output logic bus_arvalid,
	output logic bus_rready,
	// Shared bus returns
	input logic bus_awready,
	input logic bus_wready,
	input axi_xbar_pkg::resp_t bus_bresp,
	input logic bus_bvalid,
	input logic bus_arready,
	input logic [axi_xbar_pkg::DATA_W-1:0] bus_rdata,
	input axi_xbar_pkg::resp_t bus_rresp,
	input logic bus_rvalid
);

	// Which half of the owner's channels is live
	logic wr_sel;
	logic rd_sel;

	assign wr_sel = busy & is_write;
	assign rd_sel = busy & ~is_write;

	// ====================
	// Owner onto the bus
	// ====================
	assign bus_awaddr = m_awaddr[owner];
	assign bus_awvalid = wr_sel & m_awvalid[owner];
	assign bus_wdata = m_wdata[owner];
	assign bus_wstrb = m_wstrb[owner];
	assign bus_wvalid = wr_sel & m_wvalid[owner];
	assign bus_bready = wr_sel & m_bready[owner];
	// Read side only when no write was granted
	assign bus_araddr = m_araddr[owner];
	assign bus_arvalid = rd_sel & m_arvalid[owner];
	assign bus_rready = rd_sel & m_rready[owner];

	// ====================
	// Bus back to the owner
	// ====================
	for (genvar i = 0; i < axi_xbar_pkg::NUM_M; i++) begin : g_ret
		logic mine;

		assign mine = (owner == 1'(i));
		// Handshake bits reach the owner only
		assign m_awready[i] = wr_sel & mine & bus_awready;
		assign m_wready[i] = wr_sel & mine & bus_wready;
		assign m_bvalid[i] = wr_sel & mine & bus_bvalid;
		assign m_arready[i] = rd_sel & mine & bus_arready;
		assign m_rvalid[i] = rd_sel & mine & bus_rvalid;
		// Payload is shared, valid qualifies it
		assign m_bresp[i] = bus_bresp;
		assign m_rdata[i] = bus_rdata;
		assign m_rresp[i] = bus_rresp;
	end

endmodule

`default_nettype wire

/* arbiter/rr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
	input logic ACLK,
	input logic ARESETn,
	// Raw master requests
	input logic [axi_xbar_pkg::NUM_M-1:0] m_awvalid,
	input logic [axi_xbar_pkg::NUM_M-1:0] m_arvalid,
	// Response handshakes on the shared bus
	input logic bus_bvalid,
	input logic bus_bready,
	input logic bus_rvalid,
	input logic bus_rready,
	// Registered grant state
	output logic owner,
	output logic busy,
	output logic is_write
);

	logic [axi_xbar_pkg::NUM_M-1:0] req;
	// Master with first claim on the next grant
	logic ptr;
	logic pick;
	logic done;

	// Either address channel asks for the bus
	assign req = m_awvalid | m_arvalid;

	// Pointer master if it asks, else the other one
	assign pick = req[ptr] ? ptr : ~ptr;

	// Closing handshake of the kind that was granted
	assign done = is_write ? (bus_bvalid & bus_bready) : (bus_rvalid & bus_rready);

	// ====================
	// Ownership FSM
	// ====================
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			busy <= 1'b0;
			owner <= 1'b0;
			is_write <= 1'b0;
			ptr <= 1'b0;
		end else if (busy) begin
			// Hold until the response is taken
			if (done) begin
				busy <= 1'b0;
				// Next round starts past the owner
				ptr <= ~owner;
			end
		end else if (|req) begin
			busy <= 1'b1;
			owner <= pick;
			// Write beats a read from the same master
			is_write <= m_awvalid[pick];
		end
	end

endmodule

`default_nettype wire

/* common/axi_xbar_pkg.sv */
`default_nettype none

package axi_xbar_pkg;

	// ====================
	// Bus geometry
	// ====================
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	// One strobe bit per data byte
	localparam int STRB_W = DATA_W / 8;

	// Two masters share the bus toward two slaves
	localparam int NUM_M = 2;
	localparam int NUM_S = 2;

	// ====================
	// Responses and address map
	// ====================
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11;

	// Upper address half selects the slave
	localparam logic [15:0] REGION_S0 = 16'h0000;
	localparam logic [15:0] REGION_S1 = 16'h0001;

	// Same word as a bus address or as region plus offset
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		struct packed {
			logic [15:0] region;
			logic [15:0] offset;
		} fields;
	} axi_addr_u;

endpackage

`default_nettype wire
